// File: hw/stbuf_pkg.sv
// store buffer common definitions
`default_nettype none

package stbuf_pkg;

   // --------------------
   // buffer geometry
   localparam int SB_DEPTH    = 4;
   localparam int SB_PTR_W    = $clog2(SB_DEPTH);
   localparam int SB_DATA_W   = 32;
   localparam int SB_BYTE_W   = 4;
   localparam int SB_ADDR_W   = 16;
   localparam int SB_BANK_LSB = 2;   // picks lo or hi bank

   typedef logic [SB_ADDR_W-1:0] sb_addr_t;
   typedef logic [SB_DATA_W-1:0] sb_data_t;
   typedef logic [SB_BYTE_W-1:0] sb_byteen_t;
   typedef logic [SB_PTR_W-1:0]  sb_ptr_t;
   typedef logic [SB_PTR_W:0]    sb_count_t;   // 0 up to SB_DEPTH
   typedef logic [1:0]           sb_size_t;

   // --------------------
   // access sizes
   localparam sb_size_t SIZE_BYTE = 2'd0;
   localparam sb_size_t SIZE_HALF = 2'd1;
   localparam sb_size_t SIZE_WORD = 2'd2;

   // offset of the last byte touched by an access
   function automatic logic [SB_BANK_LSB-1:0] sb_last_byte(input sb_size_t size);
      case (size)
         SIZE_BYTE: sb_last_byte = 2'd0;
         SIZE_HALF: sb_last_byte = 2'd1;
         SIZE_WORD: sb_last_byte = 2'd3;
         default:   sb_last_byte = 2'd0;   // unused code
      endcase
   endfunction

endpackage

`default_nettype wire

// File: hw/stbuf_alloc.sv
// store buffer entry allocation
`timescale 1ns/1ps
`default_nettype none

module stbuf_alloc (
   input  logic                                        clk,
   input  logic                                        rst_n,
   input  logic                                        store_valid,
   input  stbuf_pkg::sb_addr_t                         store_addr,
   input  stbuf_pkg::sb_size_t                         store_size,
   input  stbuf_pkg::sb_data_t                         store_data_lo,
   input  stbuf_pkg::sb_data_t                         store_data_hi,
   output logic [stbuf_pkg::SB_DEPTH-1:0]              wr_en,
   output stbuf_pkg::sb_ptr_t                          wr_ptr,
   output logic                                        alloc_valid,
   output logic                                        alloc_dual,
   output stbuf_pkg::sb_addr_t   [stbuf_pkg::SB_DEPTH-1:0] in_addr,
   output stbuf_pkg::sb_byteen_t [stbuf_pkg::SB_DEPTH-1:0] in_byteen,
   output stbuf_pkg::sb_data_t   [stbuf_pkg::SB_DEPTH-1:0] in_data
);

   import stbuf_pkg::*;

   localparam int EXT_W = 2 * SB_BYTE_W;   // both banks side by side

   logic [SB_BANK_LSB-1:0] last_byte;
   logic [EXT_W-1:0]       size_mask;
   logic [EXT_W-1:0]       byteen_ext;
   sb_byteen_t             byteen_lo;
   sb_byteen_t             byteen_hi;
   sb_addr_t               end_addr;
   logic                   dual;
   sb_ptr_t                wr_ptr_p1;
   sb_ptr_t                wr_ptr_nxt;

   // --------------------
   // byte enables and split
   assign last_byte  = sb_last_byte(store_size);
   assign size_mask  = (EXT_W'(2) << last_byte) - EXT_W'(1);
   assign byteen_ext = size_mask << store_addr[SB_BANK_LSB-1:0];
   assign byteen_lo  = byteen_ext[SB_BYTE_W-1:0];
   assign byteen_hi  = byteen_ext[EXT_W-1:SB_BYTE_W];

   assign end_addr = store_addr + sb_addr_t'(last_byte);
   assign dual     = (store_addr[SB_BANK_LSB] != end_addr[SB_BANK_LSB]);   // crosses banks

   assign alloc_valid = store_valid;
   assign alloc_dual  = store_valid & dual;

   // --------------------
   // entry write selects
   assign wr_ptr_p1  = wr_ptr + 1'b1;
   assign wr_ptr_nxt = dual ? wr_ptr + SB_PTR_W'(2) : wr_ptr_p1;

   for (genvar i = 0; i < SB_DEPTH; i++) begin : g_entry
      logic sel_lo;
      logic sel_hi;

      assign sel_lo = (wr_ptr == sb_ptr_t'(i));
      assign sel_hi = dual & (wr_ptr_p1 == sb_ptr_t'(i));   // second half of a split store

      assign wr_en[i]     = store_valid & (sel_lo | sel_hi);
      assign in_addr[i]   = sel_lo ? store_addr    : end_addr;
      assign in_byteen[i] = sel_lo ? byteen_lo     : byteen_hi;
      assign in_data[i]   = sel_lo ? store_data_lo : store_data_hi;
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_ptr <= '0;
      end else if (store_valid) begin
         wr_ptr <= wr_ptr_nxt;   // one or two entries
      end
   end

endmodule

`default_nettype wire

// File: hw/stbuf_resolve.sv
// store commit resolution
`timescale 1ns/1ps
`default_nettype none

module stbuf_resolve (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic                           alloc_valid,
   input  logic                           alloc_dual,
   input  stbuf_pkg::sb_ptr_t             wr_ptr,
   input  logic                           commit,
   output logic [stbuf_pkg::SB_DEPTH-1:0] drain_en,
   output logic [stbuf_pkg::SB_DEPTH-1:0] flush_en
);

   import stbuf_pkg::*;

   logic                vld_dc4;
   logic                vld_dc5;
   logic                dual_dc4;
   logic                dual_dc5;
   sb_ptr_t             ptr_dc4;
   sb_ptr_t             ptr_dc5;
   sb_ptr_t             ptr_dc5_p1;
   logic [SB_DEPTH-1:0] resolve_en;

   // --------------------
   // dc3 -> dc5 staging
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         vld_dc4 <= 1'b0;
         vld_dc5 <= 1'b0;
      end else begin
         vld_dc4 <= alloc_valid;
         vld_dc5 <= vld_dc4;
      end
   end

   always_ff @(posedge clk) begin
      dual_dc4 <= alloc_dual;
      dual_dc5 <= dual_dc4;
      ptr_dc4  <= wr_ptr;    // pointer the store was written at
      ptr_dc5  <= ptr_dc4;
   end

   assign ptr_dc5_p1 = ptr_dc5 + 1'b1;

   // one or two entries resolved in dc5
   for (genvar i = 0; i < SB_DEPTH; i++) begin : g_mark
      assign resolve_en[i] = vld_dc5 & ((ptr_dc5 == sb_ptr_t'(i)) |
                                        (dual_dc5 & (ptr_dc5_p1 == sb_ptr_t'(i))));
   end

   assign drain_en = resolve_en & {SB_DEPTH{commit}};
   assign flush_en = resolve_en & {SB_DEPTH{~commit}};

endmodule

`default_nettype wire

// File: hw/stbuf_entries.sv
// store buffer entry storage and drain
`timescale 1ns/1ps
`default_nettype none

module stbuf_entries (
   input  logic                                            clk,
   input  logic                                            rst_n,
   input  logic [stbuf_pkg::SB_DEPTH-1:0]                  wr_en,
   input  stbuf_pkg::sb_addr_t   [stbuf_pkg::SB_DEPTH-1:0] in_addr,
   input  stbuf_pkg::sb_byteen_t [stbuf_pkg::SB_DEPTH-1:0] in_byteen,
   input  stbuf_pkg::sb_data_t   [stbuf_pkg::SB_DEPTH-1:0] in_data,
   input  logic [stbuf_pkg::SB_DEPTH-1:0]                  drain_en,
   input  logic [stbuf_pkg::SB_DEPTH-1:0]                  flush_en,
   input  logic                                            drain_ack,
   output logic [stbuf_pkg::SB_DEPTH-1:0]                  entry_vld,
   output logic [stbuf_pkg::SB_DEPTH-1:0]                  entry_flush,
   output stbuf_pkg::sb_addr_t   [stbuf_pkg::SB_DEPTH-1:0] entry_addr,
   output stbuf_pkg::sb_byteen_t [stbuf_pkg::SB_DEPTH-1:0] entry_byteen,
   output stbuf_pkg::sb_data_t   [stbuf_pkg::SB_DEPTH-1:0] entry_data,
   output logic                                            drain_req,
   output logic                                            drain_flushed,
   output stbuf_pkg::sb_addr_t                             drain_addr,
   output stbuf_pkg::sb_byteen_t                           drain_byteen,
   output stbuf_pkg::sb_data_t                             drain_data,
   output logic                                            full,
   output logic                                            empty
);

   import stbuf_pkg::*;

   logic [SB_DEPTH-1:0] entry_drain;   // committed, waiting for ack
   logic [SB_DEPTH-1:0] clr;
   logic                pop;
   sb_ptr_t             rd_ptr;
   sb_count_t           count;

   // --------------------
   // status bits
   assign pop = drain_ack | drain_flushed;

   for (genvar i = 0; i < SB_DEPTH; i++) begin : g_clr
      assign clr[i] = pop & (rd_ptr == sb_ptr_t'(i));
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         entry_vld   <= '0;
         entry_drain <= '0;
         entry_flush <= '0;
      end else begin
         entry_vld   <= (entry_vld | wr_en) & ~clr;
         entry_drain <= (entry_drain | drain_en) & ~clr;
         entry_flush <= (entry_flush | flush_en) & ~clr;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      for (int i = 0; i < SB_DEPTH; i++) begin
         if (wr_en[i]) begin
            entry_addr[i]   <= in_addr[i];
            entry_byteen[i] <= in_byteen[i];
            entry_data[i]   <= in_data[i];
         end
      end
   end

   // --------------------
   // head of buffer
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_ptr <= '0;
      end else if (pop) begin
         rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign drain_req     = entry_drain[rd_ptr];
   assign drain_flushed = entry_flush[rd_ptr];   // retires without an ack
   assign drain_addr    = entry_addr[rd_ptr];
   assign drain_byteen  = entry_byteen[rd_ptr];
   assign drain_data    = entry_data[rd_ptr];

   // --------------------
   // occupancy
   always_comb begin
      count = '0;
      for (int i = 0; i < SB_DEPTH; i++) begin
         count = count + sb_count_t'(entry_vld[i]);
      end
   end

   // leave room for a split store
   assign full  = (count > sb_count_t'(SB_DEPTH - 2));
   assign empty = (count == '0);

endmodule

`default_nettype wire

// File: hw/stbuf_fwd.sv
// store to load forwarding
`timescale 1ns/1ps
`default_nettype none

module stbuf_fwd (
   input  logic                                            clk,
   input  logic                                            rst_n,
   input  logic                                            load_cmp_en,
   input  stbuf_pkg::sb_addr_t                             load_addr,
   input  stbuf_pkg::sb_size_t                             load_size,
   input  stbuf_pkg::sb_ptr_t                              wr_ptr,
   input  logic [stbuf_pkg::SB_DEPTH-1:0]                  entry_vld,
   input  logic [stbuf_pkg::SB_DEPTH-1:0]                  entry_flush,
   input  stbuf_pkg::sb_addr_t   [stbuf_pkg::SB_DEPTH-1:0] entry_addr,
   input  stbuf_pkg::sb_byteen_t [stbuf_pkg::SB_DEPTH-1:0] entry_byteen,
   input  stbuf_pkg::sb_data_t   [stbuf_pkg::SB_DEPTH-1:0] entry_data,
   output stbuf_pkg::sb_byteen_t                           fwd_byteen_lo,
   output stbuf_pkg::sb_byteen_t                           fwd_byteen_hi,
   output stbuf_pkg::sb_data_t                             fwd_data_lo,
   output stbuf_pkg::sb_data_t                             fwd_data_hi
);

   import stbuf_pkg::*;

   sb_addr_t            load_end;
   logic                load_dual;
   logic                cmp_en_hi;
   logic [SB_DEPTH-1:0] match_lo;
   logic [SB_DEPTH-1:0] match_hi;
   sb_byteen_t          byteen_lo_nxt;
   sb_byteen_t          byteen_hi_nxt;
   sb_data_t            data_lo_nxt;
   sb_data_t            data_hi_nxt;

   // --------------------
   // dc2 address compare
   assign load_end  = load_addr + sb_addr_t'(sb_last_byte(load_size));
   assign load_dual = (load_addr[SB_BANK_LSB] != load_end[SB_BANK_LSB]);
   assign cmp_en_hi = load_cmp_en & load_dual;   // hi bank only for split loads

   for (genvar i = 0; i < SB_DEPTH; i++) begin : g_match
      logic live;

      assign live        = entry_vld[i] & ~entry_flush[i];
      assign match_lo[i] = load_cmp_en & live &
         (entry_addr[i][SB_ADDR_W-1:SB_BANK_LSB] == load_addr[SB_ADDR_W-1:SB_BANK_LSB]);
      assign match_hi[i] = cmp_en_hi & live &
         (entry_addr[i][SB_ADDR_W-1:SB_BANK_LSB] == load_end[SB_ADDR_W-1:SB_BANK_LSB]);
   end

   // oldest first from wr_ptr so the newest store lands last
   always_comb begin
      sb_ptr_t idx;

      byteen_lo_nxt = '0;
      byteen_hi_nxt = '0;
      data_lo_nxt   = '0;
      data_hi_nxt   = '0;
      for (int k = 0; k < SB_DEPTH; k++) begin
         idx = wr_ptr + sb_ptr_t'(k);
         for (int b = 0; b < SB_BYTE_W; b++) begin
            if (match_lo[idx] & entry_byteen[idx][b]) begin
               byteen_lo_nxt[b]      = 1'b1;
               data_lo_nxt[8*b +: 8] = entry_data[idx][8*b +: 8];
            end
            if (match_hi[idx] & entry_byteen[idx][b]) begin
               byteen_hi_nxt[b]      = 1'b1;
               data_hi_nxt[8*b +: 8] = entry_data[idx][8*b +: 8];
            end
         end
      end
   end

   // --------------------
   // dc3 result
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         fwd_byteen_lo <= '0;
         fwd_byteen_hi <= '0;
         fwd_data_lo   <= '0;
         fwd_data_hi   <= '0;
      end else begin
         fwd_byteen_lo <= byteen_lo_nxt;
         fwd_byteen_hi <= byteen_hi_nxt;
         fwd_data_lo   <= data_lo_nxt;
         fwd_data_hi   <= data_hi_nxt;
      end
   end

endmodule

`default_nettype wire

// File: hw/stbuf_top.sv
// store buffer top level
`timescale 1ns/1ps
`default_nettype none

module stbuf_top (
   input  logic                  clk,
   input  logic                  rst_n,
   // dc3 store
   input  logic                  store_valid,
   input  stbuf_pkg::sb_addr_t   store_addr,
   input  stbuf_pkg::sb_size_t   store_size,
   input  stbuf_pkg::sb_data_t   store_data_lo,
   input  stbuf_pkg::sb_data_t   store_data_hi,
   // dc5 resolve
   input  logic                  commit,
   // drain port
   output logic                  drain_req,
   output logic                  drain_flushed,
   output stbuf_pkg::sb_addr_t   drain_addr,
   output stbuf_pkg::sb_byteen_t drain_byteen,
   output stbuf_pkg::sb_data_t   drain_data,
   input  logic                  drain_ack,
   output logic                  full,
   output logic                  empty,
   // load forwarding
   input  logic                  load_cmp_en,
   input  stbuf_pkg::sb_addr_t   load_addr,
   input  stbuf_pkg::sb_size_t   load_size,
   output stbuf_pkg::sb_byteen_t fwd_byteen_lo,
   output stbuf_pkg::sb_byteen_t fwd_byteen_hi,
   output stbuf_pkg::sb_data_t   fwd_data_lo,
   output stbuf_pkg::sb_data_t   fwd_data_hi
);

   import stbuf_pkg::*;

   logic [SB_DEPTH-1:0]              wr_en;
   sb_ptr_t                          wr_ptr;
   logic                             alloc_valid;
   logic                             alloc_dual;
   sb_addr_t   [SB_DEPTH-1:0]        in_addr;
   sb_byteen_t [SB_DEPTH-1:0]        in_byteen;
   sb_data_t   [SB_DEPTH-1:0]        in_data;
   logic [SB_DEPTH-1:0]              drain_en;
   logic [SB_DEPTH-1:0]              flush_en;
   logic [SB_DEPTH-1:0]              entry_vld;
   logic [SB_DEPTH-1:0]              entry_flush;
   sb_addr_t   [SB_DEPTH-1:0]        entry_addr;
   sb_byteen_t [SB_DEPTH-1:0]        entry_byteen;
   sb_data_t   [SB_DEPTH-1:0]        entry_data;

   stbuf_alloc u_alloc (
      .clk, .rst_n, .store_valid, .store_addr, .store_size,
      .store_data_lo, .store_data_hi,
      .wr_en, .wr_ptr, .alloc_valid, .alloc_dual,
      .in_addr, .in_byteen, .in_data
   );

   stbuf_resolve u_resolve (
      .clk, .rst_n, .alloc_valid, .alloc_dual, .wr_ptr, .commit,
      .drain_en, .flush_en
   );

   stbuf_entries u_entries (
      .clk, .rst_n, .wr_en, .in_addr, .in_byteen, .in_data,
      .drain_en, .flush_en, .drain_ack,
      .entry_vld, .entry_flush, .entry_addr, .entry_byteen, .entry_data,
      .drain_req, .drain_flushed, .drain_addr, .drain_byteen, .drain_data,
      .full, .empty
   );

   // sees entries written before the load's dc2 cycle
   stbuf_fwd u_fwd (
      .clk, .rst_n, .load_cmp_en, .load_addr, .load_size, .wr_ptr,
      .entry_vld, .entry_flush, .entry_addr, .entry_byteen, .entry_data,
      .fwd_byteen_lo, .fwd_byteen_hi, .fwd_data_lo, .fwd_data_hi
   );

endmodule

`default_nettype wire

// File: test/stbuf_sva.sv
// store buffer assertions
`timescale 1ns/1ps
`default_nettype none

module stbuf_sva (
   input logic                           clk,
   input logic                           rst_n,
   input logic                           store_valid,
   input logic                           full,
   input logic                           empty,
   input logic                           drain_req,
   input logic                           drain_ack,
   input logic                           drain_flushed,
   input logic [stbuf_pkg::SB_DEPTH-1:0] entry_vld,
   input logic [stbuf_pkg::SB_DEPTH-1:0] entry_flush,
   input logic [stbuf_pkg::SB_DEPTH-1:0] drain_en,
   input logic [stbuf_pkg::SB_DEPTH-1:0] flush_en
);

   int sva_errors = 0;   // failed assertions

   // --------------------
   // entry status
   a_mark_valid: assert property (@(posedge clk) disable iff (!rst_n)
      (((drain_en | flush_en) & ~entry_vld) == '0))
      else begin
         sva_errors++;
         $error("drain or flush mark on an invalid entry");
      end

   // an entry already flushed must not be marked drainable later
   a_mark_excl: assert property (@(posedge clk) disable iff (!rst_n)
      ((drain_en & entry_flush) == '0 && !(drain_req && drain_flushed)))
      else begin
         sva_errors++;
         $error("entry marked drainable and flushed at once");
      end

   // --------------------
   // interface protocol
   a_store_full: assert property (@(posedge clk) disable iff (!rst_n) store_valid |-> !full)
      else begin
         sva_errors++;
         $error("store accepted while full");
      end

   a_ack_req: assert property (@(posedge clk) disable iff (!rst_n) drain_ack |-> drain_req)
      else begin
         sva_errors++;
         $error("drain_ack without drain_req");
      end

   a_full_empty: assert property (@(posedge clk) disable iff (!rst_n)
      empty |-> !(full || drain_req || drain_flushed))
      else begin
         sva_errors++;
         $error("full or drain activity while empty");
      end

endmodule

`default_nettype wire

// File: test/stbuf_tb.sv
// store buffer testbench
`timescale 1ns/1ps
`default_nettype none

module stbuf_tb;

   import stbuf_pkg::*;

   typedef struct packed {
      sb_addr_t   addr;
      sb_byteen_t byteen;
      sb_data_t   data;
      logic       flushed;
   } model_entry_t;

   localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
   localparam int          TEST_CYCLES = 8 + 6 * 80;   // reset plus a budget per test

   logic         clk = 1'b0;
   logic         rst_n = 1'b0;
   logic         store_valid = 1'b0;
   sb_addr_t     store_addr = '0;
   sb_size_t     store_size = '0;
   sb_data_t     store_data_lo = '0;
   sb_data_t     store_data_hi = '0;
   logic         commit = 1'b0;
   logic         drain_ack = 1'b0;
   logic         load_cmp_en = 1'b0;
   sb_addr_t     load_addr = '0;
   sb_size_t     load_size = '0;
   logic         drain_req;
   logic         drain_flushed;
   logic         full;
   logic         empty;
   sb_addr_t     drain_addr;
   sb_byteen_t   drain_byteen;
   sb_data_t     drain_data;
   sb_byteen_t   fwd_byteen_lo;
   sb_byteen_t   fwd_byteen_hi;
   sb_data_t     fwd_data_lo;
   sb_data_t     fwd_data_hi;

   logic         cmt_d0 = 1'b0;   // commit pipe, dc3 to dc5
   logic         cmt_d1 = 1'b0;
   logic         ack_hold = 1'b0;
   logic         req_seen = 1'b0;
   logic [31:0]  lfsr_state = 32'd68604;
   model_entry_t model_q[$];      // oldest entry first
   string        test_name = "reset";
   int           n_tests = 0;
   int           n_checks = 0;
   int           n_errors = 0;
   int           n_flushed = 0;
   int           err_mark = 0;

   stbuf_top dut0 (.*);

   bind stbuf_top stbuf_sva sva0 (
      .clk, .rst_n, .store_valid, .full, .empty, .drain_req, .drain_ack,
      .drain_flushed, .entry_vld, .entry_flush, .drain_en, .flush_en
   );

   initial begin
      forever #20 clk = ~clk;
   end

   initial begin : watchdog
      #(TEST_CYCLES * 2 * 40);
      $display("watchdog expired before the tests finished");
      $display("TEST FAIL");
      $finish;
   end

   // --------------------
   // helpers
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++) begin
         val        = {val[30:0], lfsr_state[0]};
         lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
      end
      take_bits = val;
   endfunction

   function automatic sb_size_t random_size();
      sb_size_t s;
      s           = sb_size_t'(take_bits(2));
      random_size = (s == 2'd3) ? SIZE_WORD : s;
   endfunction

   function automatic logic [1:0] last_offset(input sb_size_t size);
      last_offset = (size == SIZE_WORD) ? 2'd3 : ((size == SIZE_HALF) ? 2'd1 : 2'd0);
   endfunction

   task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
      n_checks++;
      assert (exp === act) else begin
         n_errors++;
         $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      n_checks++;
      assert (cond) else begin
         n_errors++;
         $display("%s: %s", test_name, msg);
      end
   endtask

   task automatic finish_test();
      n_tests++;
      $display("%s done, %0d errors", test_name, n_errors - err_mark);
   endtask

   task automatic set_hold(input logic v);
      @(posedge clk);
      ack_hold <= v;
      @(negedge clk);
   endtask

   task automatic wait_empty();
      while (!empty) @(negedge clk);
      check_true(model_q.size() == 0, "buffer empty while the model still holds entries");
   endtask

   // drive one store and queue its one or two entries
   task automatic do_store(input sb_addr_t addr, input sb_size_t size, input logic cmt);
      logic [7:0] ext;
      sb_addr_t   end_a;
      sb_data_t   lo;
      sb_data_t   hi;
      lo    = take_bits(32);
      hi    = take_bits(32);
      end_a = addr + last_offset(size);
      ext   = '0;
      for (int b = 0; b <= last_offset(size); b++) begin
         ext[addr[SB_BANK_LSB-1:0] + b] = 1'b1;   // one enable per byte touched
      end
      @(posedge clk);
      store_valid   <= 1'b1;
      store_addr    <= addr;
      store_size    <= size;
      store_data_lo <= lo;
      store_data_hi <= hi;
      cmt_d0        <= cmt;
      model_q.push_back('{addr, ext[3:0], lo, ~cmt});
      if (addr[SB_BANK_LSB] != end_a[SB_BANK_LSB]) begin
         model_q.push_back('{end_a, ext[7:4], hi, ~cmt});   // high part second
      end
      @(posedge clk);
      store_valid <= 1'b0;
      cmt_d0      <= 1'b0;
      @(negedge clk);
   endtask

   // mode 0 aligned, 1 crossing, 2 random commit
   task automatic run_stores(input string name, input int n, input int mode);
      sb_addr_t addr;
      sb_size_t size;
      logic     cmt;
      int       fl_mark;
      test_name = name;
      err_mark  = n_errors;
      fl_mark   = n_flushed;
      for (int i = 0; i < n; i++) begin
         size = random_size();
         addr = sb_addr_t'(take_bits(16));
         cmt  = 1'b1;
         if (mode == 0) addr = addr & ~sb_addr_t'(last_offset(size));
         if (mode == 1) begin
            size    = SIZE_WORD;
            addr[0] = 1'b1;
         end
         if (mode == 2) cmt = (i == 0) ? 1'b0 : (take_bits(1) != 0);
         while (full) @(negedge clk);
         do_store(addr, size, cmt);
      end
      wait_empty();
      if (mode == 2) check_true(n_flushed > fl_mark, "no flushed entry retired");
      finish_test();
   endtask

   task automatic load_check(input sb_addr_t addr, input sb_size_t size);
      sb_addr_t   end_a;
      logic       dual;
      sb_byteen_t en_lo;
      sb_byteen_t en_hi;
      sb_data_t   d_lo;
      sb_data_t   d_hi;
      end_a = addr + last_offset(size);
      dual  = (addr[SB_BANK_LSB] != end_a[SB_BANK_LSB]);
      en_lo = '0;
      en_hi = '0;
      d_lo  = '0;
      d_hi  = '0;
      foreach (model_q[k]) begin   // newest entry overwrites
         for (int b = 0; b < SB_BYTE_W; b++) begin
            if (!model_q[k].flushed && model_q[k].byteen[b]) begin
               if (model_q[k].addr[SB_ADDR_W-1:SB_BANK_LSB] == addr[SB_ADDR_W-1:SB_BANK_LSB]) begin
                  en_lo[b]      = 1'b1;
                  d_lo[8*b +: 8] = model_q[k].data[8*b +: 8];
               end
               if (dual && model_q[k].addr[SB_ADDR_W-1:SB_BANK_LSB] ==
                   end_a[SB_ADDR_W-1:SB_BANK_LSB]) begin
                  en_hi[b]      = 1'b1;
                  d_hi[8*b +: 8] = model_q[k].data[8*b +: 8];
               end
            end
         end
      end
      @(posedge clk);
      load_cmp_en <= 1'b1;
      load_addr   <= addr;
      load_size   <= size;
      @(posedge clk);
      load_cmp_en <= 1'b0;
      @(negedge clk);   // dc3 result
      check_value("fwd_byteen_lo", en_lo, fwd_byteen_lo);
      check_value("fwd_byteen_hi", en_hi, fwd_byteen_hi);
      check_value("fwd_data_lo", d_lo, fwd_data_lo);
      check_value("fwd_data_hi", d_hi, fwd_data_hi);
   endtask

   // --------------------
   // drain side
   always @(negedge clk) begin : drain_monitor
      model_entry_t head;
      req_seen = rst_n & drain_req;
      if (rst_n && (drain_req || drain_flushed)) begin
         if (model_q.size() == 0) begin
            check_true(1'b0, "drain event with no stored entry");
         end else begin
            head = model_q[0];
            check_value("head flushed", head.flushed, drain_flushed);
            if (drain_ack) begin
               check_value("drain_addr", head.addr, drain_addr);
               check_value("drain_byteen", head.byteen, drain_byteen);
               check_value("drain_data", head.data, drain_data);
            end
            if (drain_ack || drain_flushed) void'(model_q.pop_front());
            if (drain_flushed) n_flushed++;
         end
      end
   end

   always @(posedge clk) begin
      cmt_d1    <= cmt_d0;
      commit    <= cmt_d1;
      drain_ack <= rst_n & req_seen & ~ack_hold & ~drain_ack;   // one pulse per entry
   end

   // --------------------
   // test sequence
   initial begin : main
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      check_value("empty", 1, empty);
      check_value("full", 0, full);
      check_value("drain_req", 0, drain_req);
      check_value("drain_flushed", 0, drain_flushed);
      check_value("fwd_byteen_lo", 0, fwd_byteen_lo);
      finish_test();

      run_stores("aligned", 6, 0);
      run_stores("cross", 4, 1);
      run_stores("flush", 8, 2);

      test_name = "full";
      err_mark  = n_errors;
      set_hold(1'b1);
      while (model_q.size() <= SB_DEPTH - 2) begin
         check_value("full", 0, full);
         do_store(sb_addr_t'(take_bits(16)), SIZE_WORD, 1'b1);
      end
      check_value("full", 1, full);
      set_hold(1'b0);
      wait_empty();
      check_value("full", 0, full);
      finish_test();

      // overlapping stores in two words, middle one flushed
      test_name = "forward";
      err_mark  = n_errors;
      set_hold(1'b1);
      for (int i = 0; i < 3 && !full; i++) begin
         do_store(sb_addr_t'(32'h0200 | take_bits(3)), random_size(), i != 1);
      end
      repeat (4) @(negedge clk);   // last store resolved
      for (int i = 0; i < 4; i++) begin
         load_check(sb_addr_t'(32'h0200 | take_bits(3)), random_size());
      end
      set_hold(1'b0);
      wait_empty();
      load_check(16'h0202, SIZE_WORD);   // drained stores no longer forward
      finish_test();

      n_errors = n_errors + dut0.sva0.sva_errors;
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
hw/stbuf_pkg.sv
hw/stbuf_alloc.sv
hw/stbuf_resolve.sv
hw/stbuf_entries.sv
hw/stbuf_fwd.sv
hw/stbuf_top.sv
test/stbuf_sva.sv
test/stbuf_tb.sv
